//--- build.f
+incdir+.
wb_pkg.sv
unit_pkg.sv
gpr_wb_sched.sv
fpr_wb_sched.sv
operand_bypass.sv
wb_top.sv
wb_sva.sv
wb_tb.sv

//--- Makefile
# Verilator build and run for the write-back scheduler testbench

TOP := wb_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > run.log 2>&1 || true
	cat run.log
	grep -q "test passed" run.log

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log

//--- wb_tb.sv
`timescale 1ns/10ps
`default_nettype none

module wb_tb;

	localparam int NROWS = 22;
	localparam int NCYC = 20;
	// unit code for the unreserved in write
	localparam int IN_U = 7;

	logic clk = 1'b0;
	logic rst_n;
	logic flush;
	unit_pkg::gpr_reqs_t gpr_req;
	unit_pkg::gpr_rdys_t gpr_rdy;
	wb_pkg::wb_req_t gpr_in;
	logic gpr_in_rdy;
	unit_pkg::fpr_reqs_t fpr_req;
	unit_pkg::fpr_rdys_t fpr_rdy;
	wb_pkg::wb_req_t fpr_in;
	logic fpr_in_rdy;
	wb_pkg::word_t in_data;
	unit_pkg::gpr_results_t gpr_result;
	unit_pkg::fpr_results_t fpr_result;
	wb_pkg::cdb_t gpr_cdb;
	wb_pkg::cdb_t fpr_cdb;
	wb_pkg::cdb_t gpr_arch_read [2];
	wb_pkg::cdb_t gpr_rob_read [2];
	wb_pkg::cdb_t fpr_arch_read [2];
	wb_pkg::cdb_t fpr_rob_read [2];
	wb_pkg::cdb_t gpr_operand [2];
	wb_pkg::cdb_t fpr_operand [2];

	integer seed = 60598;
	logic [31:0] gres [4];
	logic [31:0] fres [7];
	int errors = 0;
	int row_err;
	int failed_rows = 0;
	int nrow = 0;

	// table columns
	int t_bus [NROWS];
	int t_mask [NROWS];
	int t_rdy [NROWS];
	int t_u2 [NROWS];
	int t_off2 [NROWS];
	int t_rdy2 [NROWS];
	int t_fl [NROWS];
	int t_nb [NROWS];
	int t_boff [NROWS][2];
	int t_btag [NROWS][2];
	int t_bun [NROWS][2];

	wb_top i_dut (.*);

	always #2 clk = !clk;

	initial begin
		#((NROWS + 1) * 24 * 4 + 200);
		$display("watchdog expired before the tests finished");
		$display("test failed");
		$finish;
	end

	task automatic add_row(input int bus, input int mask, input int rdy, input int u2,
		input int off2, input int rdy2, input int fl, input int nb, input int o0, input int g0,
		input int n0, input int o1, input int g1, input int n1);
		t_bus[nrow] = bus;
		t_mask[nrow] = mask;
		t_rdy[nrow] = rdy;
		t_u2[nrow] = u2;
		t_off2[nrow] = off2;
		t_rdy2[nrow] = rdy2;
		t_fl[nrow] = fl;
		t_nb[nrow] = nb;
		t_boff[nrow][0] = o0;
		t_btag[nrow][0] = g0;
		t_bun[nrow][0] = n0;
		t_boff[nrow][1] = o1;
		t_btag[nrow][1] = g1;
		t_bun[nrow][1] = n1;
		nrow++;
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
			row_err++;
		end
	endtask

	task automatic set_req(input int bus, input int u, input int tag);
		wb_pkg::wb_req_t r;
		r.valid = 1'b1;
		r.tag = wb_pkg::tag_t'(tag);
		if (bus == 0) begin
			case (u)
				0: gpr_req.ftoi = r;
				1: gpr_req.lw = r;
				2: gpr_req.add_sub = r;
				3: gpr_req.mov = r;
				default: gpr_in = r;
			endcase
		end else begin
			case (u)
				0, 1: begin
					fpr_req.fdiv_fsqrt = r;
					fpr_req.is_fsqrt = (u == 1);
				end
				2: fpr_req.fadd_fsub = r;
				3: fpr_req.fmul = r;
				4: fpr_req.itof = r;
				5: fpr_req.lw = r;
				6: fpr_req.fmov = r;
				default: fpr_in = r;
			endcase
		end
	endtask

	function automatic logic rdy_of(input int bus, input int u);
		if (bus == 0) begin
			case (u)
				0: return gpr_rdy.ftoi;
				1: return gpr_rdy.lw;
				2: return gpr_rdy.add_sub;
				3: return gpr_rdy.mov;
				default: return gpr_in_rdy;
			endcase
		end
		case (u)
			0, 1: return fpr_rdy.fdiv_fsqrt;
			2: return fpr_rdy.fadd_fsub;
			3: return fpr_rdy.fmul;
			4: return fpr_rdy.itof;
			5: return fpr_rdy.lw;
			6: return fpr_rdy.fmov;
			default: return fpr_in_rdy;
		endcase
	endfunction

	function automatic logic [31:0] exp_data(input int bus, input int u);
		if (u == IN_U) return in_data;
		return (bus == 0) ? gres[u] : fres[u];
	endfunction

	task automatic clear_inputs();
		gpr_req = '0;
		fpr_req = '0;
		gpr_in = '0;
		fpr_in = '0;
		flush = 1'b0;
	endtask

	// one table row, cycle 0 is the first request cycle
	task automatic run_row(input int r);
		wb_pkg::cdb_t beat;
		int hit;
		for (int c = 0; c < NCYC; c++) begin
			@(posedge clk);
			#1;
			clear_inputs();
			for (int u = 0; u < 8; u++) begin
				if (c == 0 && ((t_mask[r] >> u) & 1) == 1) set_req(t_bus[r], u, u + 1);
			end
			if (c == t_off2[r]) set_req(t_bus[r], t_u2[r], 32 + t_u2[r]);
			flush = (c == t_fl[r]);
			#2;
			for (int u = 0; u < 8; u++) begin
				if (c == 0 && ((t_mask[r] >> u) & 1) == 1) begin
					check_val($sformatf("rdy unit %0d", u), 32'(rdy_of(t_bus[r], u)),
						32'((t_rdy[r] >> u) & 1));
				end
			end
			if (c == t_off2[r]) begin
				check_val($sformatf("rdy unit %0d", t_u2[r]), 32'(rdy_of(t_bus[r], t_u2[r])),
					32'(t_rdy2[r]));
			end
			beat = (t_bus[r] == 0) ? gpr_cdb : fpr_cdb;
			hit = -1;
			for (int j = 0; j < t_nb[r]; j++) begin
				if (t_boff[r][j] == c) hit = j;
			end
			if (hit < 0) begin
				assert (!beat.valid) else begin
					$display("extra bus beat at cycle %0d with tag %0d", c, beat.tag);
					errors++;
					row_err++;
				end
			end else begin
				assert (beat.valid) else begin
					$display("expected bus beat missing at cycle %0d", c);
					errors++;
					row_err++;
				end
				check_val("cdb.tag", 32'(beat.tag), 32'(t_btag[r][hit]));
				check_val("cdb.data", beat.data, exp_data(t_bus[r], t_bun[r][hit]));
			end
		end
		// every reservation drained or flushed
		check_val("gpr_rdy", 32'(gpr_rdy), 32'h0f);
		check_val("fpr_rdy", 32'(fpr_rdy), 32'h3f);
		check_val("gpr_in_rdy", 32'(gpr_in_rdy), 32'h1);
		check_val("fpr_in_rdy", 32'(fpr_in_rdy), 32'h1);
	endtask

	task automatic run_operands();
		logic [31:0] a_data;
		logic [31:0] r_data;
		a_data = $random(seed);
		r_data = $random(seed);
		@(posedge clk);
		#1;
		clear_inputs();
		set_req(0, IN_U, 5);
		gpr_arch_read[0] = '{valid: 1'b0, tag: 6'd5, data: a_data};
		gpr_rob_read[0] = '{valid: 1'b0, tag: 6'd0, data: r_data};
		gpr_arch_read[1] = '{valid: 1'b1, tag: 6'd5, data: a_data};
		gpr_rob_read[1] = '{valid: 1'b1, tag: 6'd0, data: r_data};
		fpr_arch_read[0] = '{valid: 1'b0, tag: 6'd9, data: a_data};
		fpr_rob_read[0] = '{valid: 1'b1, tag: 6'd0, data: r_data};
		fpr_arch_read[1] = '{valid: 1'b0, tag: 6'd10, data: a_data};
		fpr_rob_read[1] = '{valid: 1'b0, tag: 6'd0, data: r_data};
		#2;
		// bus match, arch valid, rob fallback, nothing valid
		check_val("gpr_operand[0].valid", 32'(gpr_operand[0].valid), 32'h1);
		check_val("gpr_operand[0].data", gpr_operand[0].data, in_data);
		check_val("gpr_operand[1].data", gpr_operand[1].data, a_data);
		check_val("fpr_operand[0].valid", 32'(fpr_operand[0].valid), 32'h1);
		check_val("fpr_operand[0].data", fpr_operand[0].data, r_data);
		check_val("fpr_operand[0].tag", 32'(fpr_operand[0].tag), 32'd9);
		check_val("fpr_operand[1].valid", 32'(fpr_operand[1].valid), 32'h0);
		@(posedge clk);
		#1;
		clear_inputs();
	endtask

	initial begin
		clear_inputs();
		rst_n = 1'b0;
		for (int i = 0; i < 2; i++) begin
			gpr_arch_read[i] = '0;
			gpr_rob_read[i] = '0;
			fpr_arch_read[i] = '0;
			fpr_rob_read[i] = '0;
		end
		for (int i = 0; i < 4; i++) gres[i] = $random(seed);
		for (int i = 0; i < 7; i++) fres[i] = $random(seed);
		in_data = $random(seed);
		gpr_result.ftoi = gres[0];
		gpr_result.lw = gres[1];
		gpr_result.add_sub = gres[2];
		gpr_result.mov = gres[3];
		fpr_result.fdiv = fres[0];
		fpr_result.fsqrt = fres[1];
		fpr_result.fadd_fsub = fres[2];
		fpr_result.fmul = fres[3];
		fpr_result.itof = fres[4];
		fpr_result.lw = fres[5];
		fpr_result.fmov = fres[6];

		// bus mask rdy u2 off2 rdy2 flush nbeats beat0 beat1
		add_row(0, 'h01, 'h01, 0, -1, 0, -1, 1, 3, 1, 0, 0, 0, 0);
		add_row(0, 'h02, 'h02, 0, -1, 0, -1, 1, 1, 2, 1, 0, 0, 0);
		add_row(0, 'h04, 'h04, 0, -1, 0, -1, 1, 1, 3, 2, 0, 0, 0);
		add_row(0, 'h08, 'h08, 0, -1, 0, -1, 1, 1, 4, 3, 0, 0, 0);
		add_row(1, 'h01, 'h01, 0, -1, 0, -1, 1, 14, 1, 0, 0, 0, 0);
		add_row(1, 'h02, 'h02, 0, -1, 0, -1, 1, 14, 2, 1, 0, 0, 0);
		add_row(1, 'h04, 'h04, 0, -1, 0, -1, 1, 6, 3, 2, 0, 0, 0);
		add_row(1, 'h08, 'h08, 0, -1, 0, -1, 1, 4, 4, 3, 0, 0, 0);
		add_row(1, 'h10, 'h10, 0, -1, 0, -1, 1, 3, 5, 4, 0, 0, 0);
		add_row(1, 'h20, 'h20, 0, -1, 0, -1, 1, 1, 6, 5, 0, 0, 0);
		add_row(1, 'h40, 'h40, 0, -1, 0, -1, 1, 1, 7, 6, 0, 0, 0);
		// priority
		add_row(0, 'h0e, 'h02, 0, -1, 0, -1, 1, 1, 2, 1, 0, 0, 0);
		add_row(1, 'h60, 'h20, 0, -1, 0, -1, 1, 1, 6, 5, 0, 0, 0);
		// fadd_fsub against an fdiv in flight
		add_row(1, 'h01, 'h01, 2, 7, 1, -1, 2, 13, 34, 2, 14, 1, 0);
		add_row(1, 'h01, 'h01, 2, 8, 0, -1, 1, 14, 1, 0, 0, 0, 0);
		add_row(1, 'h01, 'h01, 2, 9, 1, -1, 2, 14, 1, 0, 15, 34, 2);
		// in write
		add_row(0, 'h80, 'h80, 0, -1, 0, -1, 1, 0, 8, IN_U, 0, 0, 0);
		add_row(0, 'h02, 'h02, IN_U, 1, 0, -1, 1, 1, 2, 1, 0, 0, 0);
		add_row(1, 'h80, 'h80, 0, -1, 0, -1, 1, 0, 8, IN_U, 0, 0, 0);
		// flush, the fadd_fsub slot held by the fdiv is free again
		add_row(0, 'h01, 'h01, 0, -1, 0, 1, 0, 0, 0, 0, 0, 0, 0);
		add_row(1, 'h11, 'h11, 2, 8, 1, 2, 1, 14, 34, 2, 0, 0, 0);
		add_row(0, 'h02, 'h02, 0, -1, 0, 0, 0, 0, 0, 0, 0, 0, 0);

		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int r = 0; r < nrow; r++) begin
			row_err = 0;
			run_row(r);
			if (row_err != 0) failed_rows++;
			$display("row %0d: %s", r, (row_err == 0) ? "ok" : "FAILED");
		end
		row_err = 0;
		run_operands();
		if (row_err != 0) failed_rows++;
		$display("operand forwarding: %s", (row_err == 0) ? "ok" : "FAILED");

		$display("%0d tests, %0d failed, %0d errors, %0d assertion failures", nrow + 1,
			failed_rows, errors, i_dut.i_sva.fail_count);
		if (errors == 0 && i_dut.i_sva.fail_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- wb_sva.sv
`timescale 1ns/10ps
`default_nettype none

`include "wb_params.svh"

module wb_sva (
	input wire logic                clk,
	input wire logic                rst_n,
	input wire logic                flush,
	input wire unit_pkg::gpr_reqs_t gpr_req,
	input wire unit_pkg::gpr_rdys_t gpr_rdy,
	input wire wb_pkg::cdb_t        gpr_cdb,
	input wire unit_pkg::fpr_reqs_t fpr_req,
	input wire unit_pkg::fpr_rdys_t fpr_rdy,
	input wire unit_pkg::fpr_rsv_t  fpr_mul_stage
);

	logic acc_lw;
	logic acc_add_sub;
	logic acc_mov;
	logic acc_fmul;
	logic div_at_mul;

	// failed assertions so far
	int fail_count = 0;

	assign acc_lw      = gpr_req.lw.valid && gpr_rdy.lw;
	assign acc_add_sub = gpr_req.add_sub.valid && gpr_rdy.add_sub;
	assign acc_mov     = gpr_req.mov.valid && gpr_rdy.mov;
	assign acc_fmul    = fpr_req.fmul.valid && fpr_rdy.fmul;
	assign div_at_mul  = fpr_mul_stage.valid && (fpr_mul_stage.unit == unit_pkg::fpr_fdiv
		|| fpr_mul_stage.unit == unit_pkg::fpr_fsqrt);

	// one short gpr slot per cycle
	a_one_short: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({acc_lw, acc_add_sub, acc_mov}))
		else begin
			$error("more than one short gpr unit accepted");
			fail_count++;
		end

	a_add_sub_beat: assert property (@(posedge clk) disable iff (!rst_n)
		(acc_add_sub && !flush) |=> (gpr_cdb.valid && gpr_cdb.tag == $past(gpr_req.add_sub.tag)))
		else begin
			$error("add_sub result missing from gpr bus");
			fail_count++;
		end

	a_fmul_slot: assert property (@(posedge clk) disable iff (!rst_n)
		acc_fmul |-> !div_at_mul)
		else begin
			$error("fmul accepted over an fdiv/fsqrt reservation");
			fail_count++;
		end

endmodule

bind wb_top wb_sva i_sva (
	.clk           (clk),
	.rst_n         (rst_n),
	.flush         (flush),
	.gpr_req       (gpr_req),
	.gpr_rdy       (gpr_rdy),
	.gpr_cdb       (gpr_cdb),
	.fpr_req       (fpr_req),
	.fpr_rdy       (fpr_rdy),
	.fpr_mul_stage (i_fpr_sched.rsv[`FPR_MUL_LAT])
);

`default_nettype wire

//--- wb_top.sv
`timescale 1ns/10ps
`default_nettype none

module wb_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   flush,
	input  unit_pkg::gpr_reqs_t    gpr_req,
	output unit_pkg::gpr_rdys_t    gpr_rdy,
	input  wb_pkg::wb_req_t        gpr_in,
	output logic                   gpr_in_rdy,
	input  unit_pkg::fpr_reqs_t    fpr_req,
	output unit_pkg::fpr_rdys_t    fpr_rdy,
	input  wb_pkg::wb_req_t        fpr_in,
	output logic                   fpr_in_rdy,
	input  wb_pkg::word_t          in_data,
	input  unit_pkg::gpr_results_t gpr_result,
	input  unit_pkg::fpr_results_t fpr_result,
	output wb_pkg::cdb_t           gpr_cdb,
	output wb_pkg::cdb_t           fpr_cdb,
	input  wb_pkg::cdb_t           gpr_arch_read [2],
	input  wb_pkg::cdb_t           gpr_rob_read [2],
	input  wb_pkg::cdb_t           fpr_arch_read [2],
	input  wb_pkg::cdb_t           fpr_rob_read [2],
	output wb_pkg::cdb_t           gpr_operand [2],
	output wb_pkg::cdb_t           fpr_operand [2]
);

	////////////////////
	// integer side
	////////////////////

	gpr_wb_sched i_gpr_sched (
		.clk     (clk),
		.rst_n   (rst_n),
		.flush   (flush),
		.req     (gpr_req),
		.rdy     (gpr_rdy),
		.in_req  (gpr_in),
		.in_rdy  (gpr_in_rdy),
		.in_data (in_data),
		.result  (gpr_result),
		.cdb     (gpr_cdb)
	);

	operand_bypass i_gpr_bypass (
		.arch_read (gpr_arch_read),
		.rob_read  (gpr_rob_read),
		.cdb       (gpr_cdb),
		.operand   (gpr_operand)
	);

	////////////////////
	// float side
	////////////////////

	// in_data is shared, each bus has its own in request
	fpr_wb_sched i_fpr_sched (
		.clk     (clk),
		.rst_n   (rst_n),
		.flush   (flush),
		.req     (fpr_req),
		.rdy     (fpr_rdy),
		.in_req  (fpr_in),
		.in_rdy  (fpr_in_rdy),
		.in_data (in_data),
		.result  (fpr_result),
		.cdb     (fpr_cdb)
	);

	operand_bypass i_fpr_bypass (
		.arch_read (fpr_arch_read),
		.rob_read  (fpr_rob_read),
		.cdb       (fpr_cdb),
		.operand   (fpr_operand)
	);

endmodule

`default_nettype wire

//--- operand_bypass.sv
`timescale 1ns/10ps
`default_nettype none

module operand_bypass (
	input  wb_pkg::cdb_t arch_read [2],
	input  wb_pkg::cdb_t rob_read [2],
	input  wb_pkg::cdb_t cdb,
	output wb_pkg::cdb_t operand [2]
);

	// bus broadcast carrying the awaited tag
	logic [1:0] hit;

	for (genvar i = 0; i < 2; i++) begin : g_operand
		assign hit[i] = cdb.valid && (cdb.tag == arch_read[i].tag);

		// arch tag names the producer when the arch copy is stale
		assign operand[i].valid = arch_read[i].valid || rob_read[i].valid || hit[i];
		assign operand[i].tag   = arch_read[i].tag;

		// arch copy first, then the bus, rob last
		always_comb begin
			if (arch_read[i].valid) begin
				operand[i].data = arch_read[i].data;
			end else if (hit[i]) begin
				operand[i].data = cdb.data;
			end else begin
				operand[i].data = rob_read[i].data;
			end
		end
	end

endmodule

`default_nettype wire

//--- fpr_wb_sched.sv
`timescale 1ns/10ps
`default_nettype none

`include "wb_params.svh"

module fpr_wb_sched (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   flush,
	input  unit_pkg::fpr_reqs_t    req,
	output unit_pkg::fpr_rdys_t    rdy,
	input  wb_pkg::wb_req_t        in_req,
	output logic                   in_rdy,
	input  wb_pkg::word_t          in_data,
	input  unit_pkg::fpr_results_t result,
	output wb_pkg::cdb_t           cdb
);

	// depth set by the slowest unit, fdiv/fsqrt
	unit_pkg::fpr_rsv_t rsv [`FPR_DIV_LAT];
	unit_pkg::fpr_rsv_t rsv_nxt [`FPR_DIV_LAT];

	logic acc_fdiv_fsqrt;
	logic acc_fadd_fsub;
	logic acc_fmul;
	logic acc_itof;
	logic acc_lw;
	logic acc_fmov;
	logic acc_in;

	////////////////////
	// ready and accept
	////////////////////

	// a unit needs the stage that would move into its entry point
	assign rdy.fdiv_fsqrt = 1'b1;
	assign rdy.fadd_fsub  = !rsv[`FPR_ADD_LAT].valid;
	assign rdy.fmul       = !rsv[`FPR_MUL_LAT].valid;
	assign rdy.itof       = !rsv[`FPR_ITOF_LAT].valid;
	assign rdy.lw         = !rsv[`SHORT_LAT].valid;
	assign rdy.fmov       = !rsv[`SHORT_LAT].valid && !req.lw.valid;
	assign in_rdy         = !rsv[0].valid;

	assign acc_fdiv_fsqrt = req.fdiv_fsqrt.valid && rdy.fdiv_fsqrt;
	assign acc_fadd_fsub  = req.fadd_fsub.valid && rdy.fadd_fsub;
	assign acc_fmul       = req.fmul.valid && rdy.fmul;
	assign acc_itof       = req.itof.valid && rdy.itof;
	assign acc_lw         = req.lw.valid && rdy.lw;
	assign acc_fmov       = req.fmov.valid && rdy.fmov;
	assign acc_in         = in_req.valid && in_rdy;

	////////////////////
	// reservation chain
	////////////////////

	always_comb begin
		for (int i = 0; i < `FPR_DIV_LAT - 1; i++) begin
			rsv_nxt[i] = rsv[i+1];
		end

		// top of chain, remember which of the pair
		rsv_nxt[`FPR_DIV_LAT-1].valid = acc_fdiv_fsqrt;
		rsv_nxt[`FPR_DIV_LAT-1].tag   = req.fdiv_fsqrt.tag;
		if (req.is_fsqrt) begin
			rsv_nxt[`FPR_DIV_LAT-1].unit = unit_pkg::fpr_fsqrt;
		end else begin
			rsv_nxt[`FPR_DIV_LAT-1].unit = unit_pkg::fpr_fdiv;
		end

		// merge points, shifted entry keeps the slot
		if (!rsv[`FPR_ADD_LAT].valid) begin
			rsv_nxt[`FPR_ADD_LAT-1].valid = acc_fadd_fsub;
			rsv_nxt[`FPR_ADD_LAT-1].tag   = req.fadd_fsub.tag;
			rsv_nxt[`FPR_ADD_LAT-1].unit  = unit_pkg::fpr_fadd_fsub;
		end
		if (!rsv[`FPR_MUL_LAT].valid) begin
			rsv_nxt[`FPR_MUL_LAT-1].valid = acc_fmul;
			rsv_nxt[`FPR_MUL_LAT-1].tag   = req.fmul.tag;
			rsv_nxt[`FPR_MUL_LAT-1].unit  = unit_pkg::fpr_fmul;
		end
		if (!rsv[`FPR_ITOF_LAT].valid) begin
			rsv_nxt[`FPR_ITOF_LAT-1].valid = acc_itof;
			rsv_nxt[`FPR_ITOF_LAT-1].tag   = req.itof.tag;
			rsv_nxt[`FPR_ITOF_LAT-1].unit  = unit_pkg::fpr_itof;
		end

		// lw before fmov
		if (!rsv[`SHORT_LAT].valid) begin
			rsv_nxt[`SHORT_LAT-1].valid = acc_lw || acc_fmov;
			if (acc_lw) begin
				rsv_nxt[`SHORT_LAT-1].tag  = req.lw.tag;
				rsv_nxt[`SHORT_LAT-1].unit = unit_pkg::fpr_lw;
			end else begin
				rsv_nxt[`SHORT_LAT-1].tag  = req.fmov.tag;
				rsv_nxt[`SHORT_LAT-1].unit = unit_pkg::fpr_fmov;
			end
		end

		// mispredict drops everything in flight
		if (flush) begin
			for (int i = 0; i < `FPR_DIV_LAT; i++) begin
				rsv_nxt[i].valid = 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `FPR_DIV_LAT; i++) begin
				rsv[i] <= '0;
			end
		end else begin
			rsv <= rsv_nxt;
		end
	end

	////////////////////
	// bus output
	////////////////////

	// in only gets the bus when no reservation holds it
	always_comb begin
		cdb.valid = rsv[0].valid || acc_in;
		cdb.tag   = rsv[0].valid ? rsv[0].tag : in_req.tag;
		if (!rsv[0].valid) begin
			cdb.data = in_data;
		end else begin
			case (rsv[0].unit)
				unit_pkg::fpr_fdiv:      cdb.data = result.fdiv;
				unit_pkg::fpr_fsqrt:     cdb.data = result.fsqrt;
				unit_pkg::fpr_fadd_fsub: cdb.data = result.fadd_fsub;
				unit_pkg::fpr_fmul:      cdb.data = result.fmul;
				unit_pkg::fpr_itof:      cdb.data = result.itof;
				unit_pkg::fpr_lw:        cdb.data = result.lw;
				default:                 cdb.data = result.fmov;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- gpr_wb_sched.sv
`timescale 1ns/10ps
`default_nettype none

`include "wb_params.svh"

module gpr_wb_sched (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   flush,
	input  unit_pkg::gpr_reqs_t    req,
	output unit_pkg::gpr_rdys_t    rdy,
	input  wb_pkg::wb_req_t        in_req,
	output logic                   in_rdy,
	input  wb_pkg::word_t          in_data,
	input  unit_pkg::gpr_results_t result,
	output wb_pkg::cdb_t           cdb
);

	// stage 0 is the bus end
	unit_pkg::gpr_rsv_t rsv [`GPR_FTOI_LAT];
	unit_pkg::gpr_rsv_t rsv_nxt [`GPR_FTOI_LAT];

	logic acc_ftoi;
	logic acc_lw;
	logic acc_add_sub;
	logic acc_mov;
	logic acc_short;
	logic acc_in;

	////////////////////
	// ready and accept
	////////////////////

	// lw first, then add_sub, then mov
	assign rdy.ftoi    = 1'b1;
	assign rdy.lw      = !rsv[`SHORT_LAT].valid;
	assign rdy.add_sub = !rsv[`SHORT_LAT].valid && !req.lw.valid;
	assign rdy.mov     = !rsv[`SHORT_LAT].valid && !req.lw.valid && !req.add_sub.valid;
	assign in_rdy      = !rsv[0].valid;

	assign acc_ftoi    = req.ftoi.valid && rdy.ftoi;
	assign acc_lw      = req.lw.valid && rdy.lw;
	assign acc_add_sub = req.add_sub.valid && rdy.add_sub;
	assign acc_mov     = req.mov.valid && rdy.mov;
	assign acc_short   = acc_lw || acc_add_sub || acc_mov;
	assign acc_in      = in_req.valid && in_rdy;

	////////////////////
	// reservation chain
	////////////////////

	always_comb begin
		for (int i = 0; i < `GPR_FTOI_LAT - 1; i++) begin
			rsv_nxt[i] = rsv[i+1];
		end
		rsv_nxt[`GPR_FTOI_LAT-1].valid = acc_ftoi;
		rsv_nxt[`GPR_FTOI_LAT-1].tag   = req.ftoi.tag;
		rsv_nxt[`GPR_FTOI_LAT-1].unit  = unit_pkg::gpr_ftoi;
		// shifted entry keeps the slot
		if (!rsv[`SHORT_LAT].valid) begin
			rsv_nxt[`SHORT_LAT-1].valid = acc_short;
			if (acc_lw) begin
				rsv_nxt[`SHORT_LAT-1].tag  = req.lw.tag;
				rsv_nxt[`SHORT_LAT-1].unit = unit_pkg::gpr_lw;
			end else if (acc_add_sub) begin
				rsv_nxt[`SHORT_LAT-1].tag  = req.add_sub.tag;
				rsv_nxt[`SHORT_LAT-1].unit = unit_pkg::gpr_add_sub;
			end else begin
				rsv_nxt[`SHORT_LAT-1].tag  = req.mov.tag;
				rsv_nxt[`SHORT_LAT-1].unit = unit_pkg::gpr_mov;
			end
		end
		// mispredict drops everything in flight
		if (flush) begin
			for (int i = 0; i < `GPR_FTOI_LAT; i++) begin
				rsv_nxt[i].valid = 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `GPR_FTOI_LAT; i++) begin
				rsv[i] <= '0;
			end
		end else begin
			rsv <= rsv_nxt;
		end
	end

	////////////////////
	// bus output
	////////////////////

	always_comb begin
		cdb.valid = rsv[0].valid || acc_in;
		cdb.tag   = rsv[0].valid ? rsv[0].tag : in_req.tag;
		if (!rsv[0].valid) begin
			cdb.data = in_data;
		end else begin
			case (rsv[0].unit)
				unit_pkg::gpr_ftoi:    cdb.data = result.ftoi;
				unit_pkg::gpr_lw:      cdb.data = result.lw;
				unit_pkg::gpr_add_sub: cdb.data = result.add_sub;
				default:               cdb.data = result.mov;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- unit_pkg.sv
`default_nettype none

package unit_pkg;

	typedef enum logic [1:0] {
		gpr_ftoi,
		gpr_lw,
		gpr_add_sub,
		gpr_mov
	} gpr_unit_t;

	// fdiv and fsqrt share one unit but keep separate result words
	typedef enum logic [2:0] {
		fpr_fdiv,
		fpr_fsqrt,
		fpr_fadd_fsub,
		fpr_fmul,
		fpr_itof,
		fpr_lw,
		fpr_fmov
	} fpr_unit_t;

	////////////////////
	// reservation entries
	////////////////////

	typedef struct packed {
		logic valid;
		wb_pkg::tag_t tag;
		gpr_unit_t unit;
	} gpr_rsv_t;

	typedef struct packed {
		logic valid;
		wb_pkg::tag_t tag;
		fpr_unit_t unit;
	} fpr_rsv_t;

	////////////////////
	// grouped unit signals
	////////////////////

	typedef struct packed {
		wb_pkg::wb_req_t ftoi;
		wb_pkg::wb_req_t lw;
		wb_pkg::wb_req_t add_sub;
		wb_pkg::wb_req_t mov;
	} gpr_reqs_t;

	typedef struct packed {
		logic ftoi;
		logic lw;
		logic add_sub;
		logic mov;
	} gpr_rdys_t;

	typedef struct packed {
		wb_pkg::word_t ftoi;
		wb_pkg::word_t lw;
		wb_pkg::word_t add_sub;
		wb_pkg::word_t mov;
	} gpr_results_t;

	typedef struct packed {
		wb_pkg::wb_req_t fdiv_fsqrt;
		logic is_fsqrt;
		wb_pkg::wb_req_t fadd_fsub;
		wb_pkg::wb_req_t fmul;
		wb_pkg::wb_req_t itof;
		wb_pkg::wb_req_t lw;
		wb_pkg::wb_req_t fmov;
	} fpr_reqs_t;

	typedef struct packed {
		logic fdiv_fsqrt;
		logic fadd_fsub;
		logic fmul;
		logic itof;
		logic lw;
		logic fmov;
	} fpr_rdys_t;

	typedef struct packed {
		wb_pkg::word_t fdiv;
		wb_pkg::word_t fsqrt;
		wb_pkg::word_t fadd_fsub;
		wb_pkg::word_t fmul;
		wb_pkg::word_t itof;
		wb_pkg::word_t lw;
		wb_pkg::word_t fmov;
	} fpr_results_t;

endpackage

`default_nettype wire

//--- wb_pkg.sv
`default_nettype none

`include "wb_params.svh"

package wb_pkg;

	// rob tag of one instruction
	typedef logic [`WB_TAG_W-1:0] tag_t;

	// one result word
	typedef logic [`WB_DATA_W-1:0] word_t;

	// write-back request from a unit
	typedef struct packed {
		logic valid;
		tag_t tag;
	} wb_req_t;

	// bus beat, also used for operand reads
	typedef struct packed {
		logic valid;
		tag_t tag;
		word_t data;
	} cdb_t;

endpackage

`default_nettype wire

//--- wb_params.svh
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

////////////////////
// bus widths
////////////////////

// rob tag
`define WB_TAG_W 6

// result word
`define WB_DATA_W 32

////////////////////
// unit latencies
////////////////////

// cycles from accept to bus beat
`define GPR_FTOI_LAT 3

// also the depth of the fpr chain
`define FPR_DIV_LAT 14
`define FPR_ADD_LAT 6
`define FPR_MUL_LAT 4
`define FPR_ITOF_LAT 3

// lw, add_sub, mov and fmov
`define SHORT_LAT 1

`endif
